/* design/spw_tx_pkg.sv */
// Shared types and credit limits for the SpaceWire transmitter
// Credit values follow ECSS-E-ST-50-12C and are not meant to be changed
`default_nettype none

package spw_tx_pkg;

	// ------------------------------
	// Character kinds
	// ------------------------------

	// Character handed from controller to encoder
	typedef enum logic [2:0]
	{
		k_data,
		k_eop,
		k_eep,
		k_fct,
		k_null
	} char_kind_t;

	// Controller selection states
	typedef enum logic [1:0]
	{
		st_null,
		st_fct,
		st_nchar,
		// NULL sent while host handshake closes
		st_ack_wait
	} ctrl_state_t;

	// N-char kinds offered by the host
	typedef enum logic [1:0]
	{
		h_data,
		h_eop,
		h_eep
	} tx_kind_t;

	// ------------------------------
	// Credit
	// ------------------------------

	// Credit granted by one received FCT
	localparam int CREDIT_STEP = 8;
	// Seven outstanding FCTs at most
	localparam int CREDIT_MAX = 56;
	localparam int CREDIT_W = 6;

endpackage

`default_nettype wire

/* design/spw_tx_fct_credit.sv */
// gotfct_tx must be a one-cycle pulse already synchronous to pclk_tx
// An FCT that would exceed 56 is dropped and latches credit_error until reset
`timescale 1ns/10ps
`default_nettype none

module spw_tx_fct_credit import spw_tx_pkg::*;
(
	input  logic                pclk_tx,
	input  logic                enable_tx,
	input  logic                gotfct_tx,
	input  logic                char_sent,
	output logic [CREDIT_W-1:0] credit,
	output logic                credit_error
);

	// One extra bit to see an overflow before it wraps
	localparam logic [CREDIT_W:0] STEP_X = (CREDIT_W+1)'(CREDIT_STEP);
	localparam logic [CREDIT_W:0] MAX_X = (CREDIT_W+1)'(CREDIT_MAX);

	logic              take_one;
	logic [CREDIT_W:0] credit_dec;
	logic [CREDIT_W:0] credit_fct;
	logic              fct_over;

	// ------------------------------
	// Next credit
	// ------------------------------

	// Never go below zero, even on a stray char_sent
	assign take_one = char_sent & (credit != '0);

	always_comb
	begin
		credit_dec = {1'b0, credit} - {{CREDIT_W{1'b0}}, take_one};
		// Credit if this FCT were accepted
		credit_fct = credit_dec + STEP_X;
		fct_over = credit_fct > MAX_X;
	end

	// ------------------------------
	// Counter and error flag
	// ------------------------------

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			credit <= '0;
			credit_error <= 1'b0;
		end
		else
		begin
			if (gotfct_tx && !fct_over)
			begin
				credit <= credit_fct[CREDIT_W-1:0];
			end
			else
			begin
				// Refused FCT still lets the N-char count down
				credit <= credit_dec[CREDIT_W-1:0];
			end

			// Sticky until reset
			if (gotfct_tx && fct_over)
			begin
				credit_error <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/spw_tx_ctrl.sv */
// Picks the next character once per char_load. FCT first, N-char on credit, else NULL
// Both request ports are four-phase. The host holds tx_kind and tx_data while tx_req is high
`timescale 1ns/10ps
`default_nettype none

module spw_tx_ctrl import spw_tx_pkg::*;
(
	input  logic                pclk_tx,
	input  logic                enable_tx,
	input  logic                tx_req,
	input  tx_kind_t            tx_kind,
	input  logic [7:0]          tx_data,
	output logic                tx_ack,
	input  logic                fct_req,
	output logic                fct_ack,
	input  logic [CREDIT_W-1:0] credit,
	input  logic                char_load,
	output char_kind_t          next_kind,
	output logic [7:0]          next_data,
	output logic                char_sent
);

	ctrl_state_t state;
	tx_kind_t    host_kind;
	logic [7:0]  host_data;
	logic        load_fct;
	logic        load_nchar;
	logic        fct_pend;
	logic        host_pend;

	// ------------------------------
	// Request qualification
	// ------------------------------

	// Encoder takes the current selection
	assign load_fct = char_load & (state == st_fct);
	assign load_nchar = char_load & (state == st_nchar);
	assign char_sent = load_nchar;

	// Request being loaded now or already acked is not pending
	assign fct_pend = fct_req & ~fct_ack & ~load_fct;
	// Far end must have room for one more N-char
	assign host_pend = tx_req & ~tx_ack & ~load_nchar & (credit != '0);

	// ------------------------------
	// Selection FSM
	// ------------------------------

	// Selection only moves on char_load
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			state <= st_null;
		end
		else if (char_load)
		begin
			if (fct_pend)
				state <= st_fct;
			else if (host_pend)
				state <= st_nchar;
			else if (state == st_nchar)
				state <= st_ack_wait;
			else
				state <= st_null;
		end
	end

	// Host N-char held for the encoder
	always_ff @(posedge pclk_tx)
	begin
		if (char_load && !fct_pend && host_pend)
		begin
			host_kind <= tx_kind;
			host_data <= tx_data;
		end
	end

	always_comb
	begin
		next_data = host_data;
		case (state)
			st_fct:
				next_kind = k_fct;
			st_nchar:
			begin
				case (host_kind)
					h_data:  next_kind = k_data;
					h_eop:   next_kind = k_eop;
					default: next_kind = k_eep;
				endcase
			end
			// st_null and st_ack_wait
			default:
				next_kind = k_null;
		endcase
	end

	// ------------------------------
	// Acknowledges
	// ------------------------------

	// Rise one cycle after the load, fall once req is gone
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			tx_ack <= 1'b0;
			fct_ack <= 1'b0;
		end
		else
		begin
			if (load_nchar)
				tx_ack <= 1'b1;
			else if (!tx_req)
				tx_ack <= 1'b0;

			if (load_fct)
				fct_ack <= 1'b1;
			else if (!fct_req)
				fct_ack <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* design/spw_tx_char_encoder.sv */
// Runs without gaps. char_load is high on the first bit of every character
// Odd parity covers previous payload plus own parity and flag. Starts from zero
// Control code bit 0 leaves first. EOP goes out as 0 then 1
`timescale 1ns/10ps
`default_nettype none

module spw_tx_char_encoder import spw_tx_pkg::*;
(
	input  logic       pclk_tx,
	input  logic       enable_tx,
	input  char_kind_t next_kind,
	input  logic [7:0] next_data,
	output logic       char_load,
	output logic       dout,
	output logic       sout
);

	// Line order FCT 00, EOP 01, EEP 10, ESC 11
	localparam logic [1:0] CODE_FCT = 2'b00;
	localparam logic [1:0] CODE_EOP = 2'b10;
	localparam logic [1:0] CODE_EEP = 2'b01;
	localparam logic [1:0] CODE_ESC = 2'b11;

	logic [3:0] bit_cnt;
	logic [8:0] shift_reg;
	logic       prev_par;
	logic [1:0] ctrl_code;
	logic [9:0] char_bits;
	logic [3:0] char_len;
	logic       char_par;
	logic       d_next;

	// ------------------------------
	// Character build
	// ------------------------------

	always_comb
	begin
		case (next_kind)
			k_eop:   ctrl_code = CODE_EOP;
			k_eep:   ctrl_code = CODE_EEP;
			default: ctrl_code = CODE_FCT;
		endcase
	end

	// Bit 0 is the parity bit, bit 1 the flag
	always_comb
	begin
		case (next_kind)
			k_data:
			begin
				char_bits = {next_data, 1'b0, ~prev_par};
				char_len = 4'd10;
				char_par = ^next_data;
			end
			k_null:
			begin
				// ESC then FCT, inner parity 0 as ESC payload is even
				char_bits = {2'b00, CODE_FCT, 1'b1, 1'b0, CODE_ESC, 1'b1, prev_par};
				char_len = 4'd8;
				char_par = 1'b0;
			end
			default:
			begin
				char_bits = {6'd0, ctrl_code, 1'b1, prev_par};
				char_len = 4'd4;
				char_par = ^ctrl_code;
			end
		endcase
	end

	// ------------------------------
	// Shift out and D/S line
	// ------------------------------

	assign char_load = (bit_cnt == 4'd0);
	assign d_next = char_load ? char_bits[0] : shift_reg[0];

	always_ff @(posedge pclk_tx)
	begin
		if (char_load)
			shift_reg <= char_bits[9:1];
		else
			shift_reg <= {1'b0, shift_reg[8:1]};
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			bit_cnt <= 4'd0;
			prev_par <= 1'b0;
			dout <= 1'b0;
			sout <= 1'b0;
		end
		else
		begin
			dout <= d_next;
			// Strobe toggles when data repeats
			if (d_next == dout)
				sout <= ~sout;

			if (char_load)
			begin
				bit_cnt <= char_len - 4'd1;
				prev_par <= char_par;
			end
			else
				bit_cnt <= bit_cnt - 4'd1;
		end
	end

endmodule

`default_nettype wire

/* design/spw_tx_top.sv */
// Transmit half only. No receiver, link FSM or time-codes
// gotfct_tx is expected already synchronous to pclk_tx
`timescale 1ns/10ps
`default_nettype none

module spw_tx_top import spw_tx_pkg::*;
(
	input  logic                pclk_tx,
	input  logic                enable_tx,
	input  logic                tx_req,
	input  tx_kind_t            tx_kind,
	input  logic [7:0]          tx_data,
	output logic                tx_ack,
	input  logic                fct_req,
	output logic                fct_ack,
	input  logic                gotfct_tx,
	output logic [CREDIT_W-1:0] credit,
	output logic                credit_error,
	output logic                dout,
	output logic                sout
);

	// Controller to encoder
	char_kind_t next_kind;
	logic [7:0] next_data;
	logic       char_load;
	// Controller to credit counter
	logic       char_sent;

	spw_tx_ctrl u_ctrl
	(
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx),
		.tx_req    (tx_req),
		.tx_kind   (tx_kind),
		.tx_data   (tx_data),
		.tx_ack    (tx_ack),
		.fct_req   (fct_req),
		.fct_ack   (fct_ack),
		.credit    (credit),
		.char_load (char_load),
		.next_kind (next_kind),
		.next_data (next_data),
		.char_sent (char_sent)
	);

	spw_tx_fct_credit u_credit
	(
		.pclk_tx      (pclk_tx),
		.enable_tx    (enable_tx),
		.gotfct_tx    (gotfct_tx),
		.char_sent    (char_sent),
		.credit       (credit),
		.credit_error (credit_error)
	);

	spw_tx_char_encoder u_encoder
	(
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx),
		.next_kind (next_kind),
		.next_data (next_data),
		.char_load (char_load),
		.dout      (dout),
		.sout      (sout)
	);

endmodule

`default_nettype wire

/* sim/spw_tx_sva.sv */
// Line coding and handshake assertions, bound to spw_tx_top
// Checks are off while enable_tx is low
`timescale 1ns/10ps
`default_nettype none

module spw_tx_sva
(
	input logic pclk_tx,
	input logic enable_tx,
	input logic dout,
	input logic sout,
	input logic tx_req,
	input logic tx_ack,
	input logic fct_req,
	input logic fct_ack
);

	// ------------------------------
	// D/S coding
	// ------------------------------

	// One of the pair moves per bit once the line runs
	assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		$past(enable_tx) |-> ($changed(dout) != $changed(sout)))
		else $error("D/S pair broke the one-change-per-bit rule");

	// ------------------------------
	// Four-phase handshakes
	// ------------------------------

	// Ack is registered off the load, so req is judged one cycle back
	assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		$rose(tx_ack) |-> $past(tx_req))
		else $error("tx_ack rose without tx_req");
	assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		$rose(fct_ack) |-> $past(fct_req))
		else $error("fct_ack rose without fct_req");

	// Request held until acked
	assert property (@(posedge pclk_tx) disable iff (!enable_tx) $fell(tx_req) |-> tx_ack)
		else $error("tx_req dropped before tx_ack");
	assert property (@(posedge pclk_tx) disable iff (!enable_tx) $fell(fct_req) |-> fct_ack)
		else $error("fct_req dropped before fct_ack");

endmodule

`default_nettype wire

/* sim/spw_tx_tb.sv */
// Testbench for spw_tx_top, driven by sim/spw_tx_vectors.txt from the project root
// Decodes the D/S line back into characters and checks parity, order and credit
// Credit and FCT counts are compared only at quiet points after a wait
`timescale 1ns/10ps
`default_nettype none

module spw_tx_tb import spw_tx_pkg::*; ();

	logic                pclk_tx = 1'b0;
	logic                enable_tx;
	logic                tx_req;
	tx_kind_t            tx_kind;
	logic [7:0]          tx_data;
	logic                tx_ack;
	logic                fct_req;
	logic                fct_ack;
	logic                gotfct_tx;
	logic [CREDIT_W-1:0] credit;
	logic                credit_error;
	logic                dout;
	logic                sout;

	// Vectors and bookkeeping
	logic [15:0] vec_mem [0:255];
	logic [9:0]  host_q[$];
	logic [9:0]  exp_q[$];
	integer      seed;
	int          errors = 0;
	int          tests = 0;
	int          model_credit = 0;
	logic        model_err = 1'b0;
	int          nchar_cnt = 0;
	int          host_total = 0;
	int          fct_total = 0;
	int          fct_seen = 0;
	int          fct_allow = 0;
	int          null_cnt = 0;
	int          wd_cycles = 0;
	logic        wd_armed = 1'b0;

	// Line decoder state
	logic        last_ds = 1'b0;
	logic [9:0]  bits = '0;
	int          pos = 0;
	logic        prev_x = 1'b0;
	logic        esc_pend = 1'b0;

	spw_tx_top DUT
	(
		.pclk_tx      (pclk_tx),
		.enable_tx    (enable_tx),
		.tx_req       (tx_req),
		.tx_kind      (tx_kind),
		.tx_data      (tx_data),
		.tx_ack       (tx_ack),
		.fct_req      (fct_req),
		.fct_ack      (fct_ack),
		.gotfct_tx    (gotfct_tx),
		.credit       (credit),
		.credit_error (credit_error),
		.dout         (dout),
		.sout         (sout)
	);

	bind spw_tx_top spw_tx_sva u_sva
	(
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx),
		.dout      (dout),
		.sout      (sout),
		.tx_req    (tx_req),
		.tx_ack    (tx_ack),
		.fct_req   (fct_req),
		.fct_ack   (fct_ack)
	);

	// 8 ns period
	always #4 pclk_tx = ~pclk_tx;

	// ------------------------------
	// Checks
	// ------------------------------

	task automatic check_value(input string name, input int expected, input int actual);
		tests++;
		if (expected != actual)
		begin
			errors++;
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
		end
		else
			$display("ok   %s: %0d", name, actual);
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("Error: %s", what);
	endtask

	// ------------------------------
	// Line decoder
	// ------------------------------

	// Kind 0 data, 1 EOP, 2 EEP
	task automatic take_nchar(input logic [1:0] kind, input logic [7:0] data);
		logic [9:0] exp_val;
		nchar_cnt++;
		model_credit--;
		if (model_credit < 0)
			report_error("N-char left the line without credit");
		if (exp_q.size() == 0)
			report_error("N-char sent with no host request pending");
		else
		begin
			exp_val = exp_q.pop_front();
			check_value($sformatf("N-char %0d", nchar_cnt), exp_val, {kind, data});
		end
	endtask

	task automatic decode_char();
		logic [1:0] code;
		// Odd parity over last payload, own parity and flag
		if ((prev_x ^ bits[0] ^ bits[1]) != 1'b1)
			report_error("parity error on a decoded character");
		if (bits[1])
		begin
			code = {bits[2], bits[3]};
			prev_x = bits[2] ^ bits[3];
			if (code == 2'b11)
			begin
				if (esc_pend)
					report_error("two ESC characters in a row");
				esc_pend = 1'b1;
			end
			else if (esc_pend)
			begin
				// ESC plus FCT is a NULL
				esc_pend = 1'b0;
				if (code == 2'b00)
					null_cnt++;
				else
					report_error("ESC followed by an end of packet");
			end
			else if (code == 2'b00)
			begin
				if (fct_allow == 0)
					report_error("FCT sent without a request");
				else
				begin
					fct_allow--;
					fct_seen++;
				end
			end
			else
				take_nchar((code == 2'b01) ? 2'd1 : 2'd2, 8'h00);
		end
		else
		begin
			prev_x = ^bits[9:2];
			if (esc_pend)
				report_error("ESC followed by a data character");
			esc_pend = 1'b0;
			take_nchar(2'd0, bits[9:2]);
		end
	endtask

	// One bit per change of dout xor sout
	always @(negedge pclk_tx)
	begin
		if (!enable_tx)
		begin
			last_ds = 1'b0;
			pos = 0;
			prev_x = 1'b0;
			esc_pend = 1'b0;
		end
		else if ((dout ^ sout) != last_ds)
		begin
			last_ds = dout ^ sout;
			bits[pos] = dout;
			pos++;
			if (pos >= 2 && pos == (bits[1] ? 4 : 10))
			begin
				decode_char();
				pos = 0;
			end
		end
	end

	// ------------------------------
	// Host and FCT request drivers
	// ------------------------------

	// Random gap before each host request
	initial
	begin : host_driver
		logic [9:0] item;
		int         gap;
		forever
		begin
			@(negedge pclk_tx);
			if (host_q.size() != 0 && enable_tx)
			begin
				item = host_q.pop_front();
				gap = $random(seed) & 32'h7;
				repeat (gap) @(negedge pclk_tx);
				tx_kind = tx_kind_t'(item[9:8]);
				tx_data = item[7:0];
				tx_req = 1'b1;
				while (!tx_ack)
					@(negedge pclk_tx);
				tx_req = 1'b0;
				while (tx_ack)
					@(negedge pclk_tx);
			end
		end
	end

	task automatic send_fct(input int line);
		int waited;
		fct_allow++;
		fct_total++;
		@(negedge pclk_tx);
		fct_req = 1'b1;
		waited = 0;
		while (!fct_ack && waited < 100)
		begin
			@(negedge pclk_tx);
			waited++;
		end
		if (!fct_ack)
			report_error("fct_ack never rose");
		fct_req = 1'b0;
		waited = 0;
		while (fct_ack && waited < 100)
		begin
			@(negedge pclk_tx);
			waited++;
		end
		if (fct_ack)
			report_error("fct_ack never fell after fct_req dropped");
		// Let the FCT finish on the line
		repeat (6) @(negedge pclk_tx);
		check_value($sformatf("vector %0d FCT count", line), fct_total, fct_seen);
	endtask

	task automatic pulse_gotfct();
		if (model_credit + CREDIT_STEP > CREDIT_MAX)
			model_err = 1'b1;
		else
			model_credit = model_credit + CREDIT_STEP;
		@(negedge pclk_tx);
		gotfct_tx = 1'b1;
		@(negedge pclk_tx);
		gotfct_tx = 1'b0;
	endtask

	task automatic apply_reset();
		if (host_q.size() != 0 || exp_q.size() != 0)
			report_error("reset requested with host characters still pending");
		@(negedge pclk_tx);
		enable_tx = 1'b0;
		repeat (2) @(negedge pclk_tx);
		// Running line must drop to idle
		check_value("mid-run reset dout", 0, dout);
		check_value("mid-run reset sout", 0, sout);
		model_credit = 0;
		model_err = 1'b0;
		enable_tx = 1'b1;
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------

	initial
	begin : main_seq
		int         idx;
		int         n_chars;
		int         n_waits;
		logic [3:0] cmd;
		logic [11:0] arg;
		seed = 32'h1165;
		enable_tx = 1'b0;
		tx_req = 1'b0;
		fct_req = 1'b0;
		gotfct_tx = 1'b0;
		tx_kind = h_data;
		tx_data = 8'h00;
		for (idx = 0; idx < 256; idx++)
			vec_mem[idx] = 16'h0000;
		$readmemh("sim/spw_tx_vectors.txt", vec_mem);

		// Watchdog budget from the vector contents
		n_chars = 1;
		n_waits = 0;
		for (idx = 0; idx < 256 && vec_mem[idx][15:12] != 4'h0; idx++)
		begin
			if (vec_mem[idx][15:12] inside {4'h1, 4'h2, 4'h3})
				n_chars++;
			else if (vec_mem[idx][15:12] == 4'h4)
				n_waits = n_waits + int'(vec_mem[idx][11:0]);
		end
		wd_cycles = 20 * n_chars * 10 + n_waits;
		wd_armed = 1'b1;

		// Line idle during reset
		repeat (2)
		begin
			@(negedge pclk_tx);
			check_value("reset dout", 0, dout);
			check_value("reset sout", 0, sout);
		end
		enable_tx = 1'b1;

		idx = 0;
		while (idx < 256 && vec_mem[idx][15:12] != 4'h0)
		begin
			cmd = vec_mem[idx][15:12];
			arg = vec_mem[idx][11:0];
			case (cmd)
				4'h1:
				begin
					host_q.push_back(arg[9:0]);
					exp_q.push_back((arg[9:8] == 2'd0) ? arg[9:0] : {arg[9:8], 8'h00});
					host_total++;
				end
				4'h2:
					send_fct(idx);
				4'h3:
					pulse_gotfct();
				4'h4:
					repeat (arg) @(negedge pclk_tx);
				4'h5:
				begin
					check_value($sformatf("vector %0d credit", idx), model_credit, credit);
					check_value($sformatf("vector %0d credit_error", idx), model_err,
						credit_error);
				end
				4'h6:
				begin
					check_value($sformatf("vector %0d N-char count", idx), arg, nchar_cnt);
					// Blocked requests stay unacknowledged
					if (arg < host_total)
						check_value($sformatf("vector %0d tx_ack", idx), 0, tx_ack);
				end
				4'h7:
					apply_reset();
				default:
					report_error($sformatf("unknown command at vector %0d", idx));
			endcase
			idx++;
		end

		if (exp_q.size() != 0)
			report_error("host characters were never sent");
		if (null_cnt == 0)
			report_error("no NULL characters seen on the line");
		$display("%0d checks, %0d errors, %0d NULLs", tests, errors, null_cnt);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin : watchdog
		wait (wd_armed);
		repeat (wd_cycles) @(posedge pclk_tx);
		$display("Watchdog expired after %0d cycles, run did not finish", wd_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/spw_tx_vectors.txt */
// cmd arg as one hex word: 1 host N-char (kind in bits 9:8, data), 2 FCT request, 3 gotfct
// 4 wait arg cycles, 5 check credit and credit_error, 6 expect N-char count, 7 reset
4064 // idle line, NULLs only
6000
5000
1041 1042 1100 1055 1200
10a5 10ff 1000 1033
4064 // no credit yet
6000
5000
3000 4190 6008 5000
3000 4064 6009 5000
2000 4010 5000
7000 // overflow run
3000 3000 3000 3000
3000 3000 3000 3000
4008 5000
7000 5000
0000

/* all.f */
design/spw_tx_pkg.sv
design/spw_tx_fct_credit.sv
design/spw_tx_ctrl.sv
design/spw_tx_char_encoder.sv
design/spw_tx_top.sv
sim/spw_tx_sva.sv
sim/spw_tx_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = spw_tx_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
